//--- hdl/streamer_macros.svh
`ifndef STREAMER_MACROS_SVH
`define STREAMER_MACROS_SVH

// Memory port widths
`define STREAMER_AW 16
`define STREAMER_DW 32

// Word count and stride width
`define STREAMER_CW 8

// Buffer depths
`define STREAMER_LOAD_DEPTH 4
`define STREAMER_STORE_DEPTH 2

// Reads that may wait for their response
`define STREAMER_TAG_DEPTH 4

`endif

//--- hdl/streamer_mem_pkg.sv
`include "streamer_macros.svh"

package streamer_mem_pkg;

  // Word address on the shared memory port
  typedef logic [`STREAMER_AW-1:0] addr_t;

  // One memory data word
  typedef logic [`STREAMER_DW-1:0] data_t;

  // Read tag naming the load channel that owns a response
  typedef logic [1:0] tag_t;

endpackage

//--- hdl/streamer_job_pkg.sv
`include "streamer_macros.svh"

package streamer_job_pkg;

  // Number of words in one stream
  typedef logic [`STREAMER_CW-1:0] count_t;

  // Address step between two words of a stream
  typedef logic [`STREAMER_CW-1:0] stride_t;

  // Stream index, also the arbiter slot and the read tag
  typedef enum logic [1:0] {
    X = 2'd0,
    W = 2'd1,
    Y = 2'd2,
    Z = 2'd3
  } stream_id_e;

endpackage

//--- hdl/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
  parameter int unsigned DEPTH = 4,
  parameter type payload_t = logic [31:0],
  localparam int unsigned PW = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int unsigned CW = $clog2(DEPTH + 1)
) (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          push_i,
  input  payload_t      data_i,
  output logic          full_o,
  input  logic          pop_i,
  output payload_t      data_o,
  output logic          empty_o,
  output logic [CW-1:0] count_o
);

  payload_t      mem_q [DEPTH];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Head word is visible as soon as it is stored
  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CW'(DEPTH));
  assign count_o = count_q;

  no_push_when_full: assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_o)
    else $error("stream_fifo: push while full");

  no_pop_when_empty: assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o)
    else $error("stream_fifo: pop while empty");

endmodule

//--- hdl/addr_gen.sv
`timescale 1ns/1ps

module addr_gen (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      start_i,
  input  streamer_mem_pkg::addr_t   base_i,
  input  streamer_job_pkg::stride_t stride_i,
  input  streamer_job_pkg::count_t  len_i,
  input  logic                      next_i,
  output streamer_mem_pkg::addr_t   addr_o,
  output logic                      active_o,
  output logic                      last_o
);

  streamer_mem_pkg::addr_t  addr_q;
  streamer_job_pkg::count_t left_q;

  // Words still to be addressed
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      left_q <= '0;
    end else if (start_i) begin
      left_q <= len_i;
    end else if (next_i) begin
      left_q <= left_q - 1'b1;
    end
  end

  // Wraps modulo the address space
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q <= base_i;
    end else if (next_i) begin
      addr_q <= addr_q + streamer_mem_pkg::addr_t'(stride_i);
    end
  end

  assign addr_o   = addr_q;
  assign active_o = (left_q != '0);
  assign last_o   = (left_q == streamer_job_pkg::count_t'(1));

  no_step_when_done: assert property (@(posedge clk_i) disable iff (rst_i) next_i |-> active_o)
    else $error("addr_gen: step requested with no words left");

endmodule

//--- hdl/load_channel.sv
`timescale 1ns/1ps
`include "streamer_macros.svh"

module load_channel #(
  parameter streamer_job_pkg::stream_id_e ID = streamer_job_pkg::X
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      start_i,
  input  streamer_mem_pkg::addr_t   base_i,
  input  streamer_job_pkg::stride_t stride_i,
  input  streamer_job_pkg::count_t  len_i,
  output logic                      req_o,
  output streamer_mem_pkg::addr_t   addr_o,
  input  logic                      gnt_i,
  input  logic                      rvalid_i,
  input  streamer_mem_pkg::data_t   rdata_i,
  output logic                      valid_o,
  input  logic                      ready_i,
  output streamer_mem_pkg::data_t   data_o,
  output logic                      idle_o
);

  localparam int unsigned DEPTH = `STREAMER_LOAD_DEPTH;
  localparam int unsigned CW    = $clog2(DEPTH + 1);

  logic          ag_active;
  logic          issue;
  logic          pop;
  logic          empty;
  logic [CW-1:0] buf_count;
  logic [CW-1:0] inflight_q;
  logic [CW:0]   credit_used;

  assign issue = req_o && gnt_i;

  addr_gen u_addr_gen (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .start_i  (start_i),
    .base_i   (base_i),
    .stride_i (stride_i),
    .len_i    (len_i),
    .next_i   (issue),
    .addr_o   (addr_o),
    .active_o (ag_active),
    .last_o   ()
  );

  // Every read in flight already owns a buffer slot
  assign credit_used = {1'b0, inflight_q} + {1'b0, buf_count};
  assign req_o       = ag_active && (credit_used < DEPTH);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      inflight_q <= '0;
    end else if (issue && !rvalid_i) begin
      inflight_q <= inflight_q + 1'b1;
    end else if (rvalid_i && !issue) begin
      inflight_q <= inflight_q - 1'b1;
    end
  end

  stream_fifo #(
    .DEPTH     (DEPTH),
    .payload_t (streamer_mem_pkg::data_t)
  ) u_buf (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (rvalid_i),
    .data_i  (rdata_i),
    .full_o  (),
    .pop_i   (pop),
    .data_o  (data_o),
    .empty_o (empty),
    .count_o (buf_count)
  );

  assign valid_o = !empty;
  assign pop     = valid_o && ready_i;
  assign idle_o  = !ag_active && (inflight_q == '0) && empty;

  no_orphan_response: assert property (
    @(posedge clk_i) disable iff (rst_i) rvalid_i |-> (inflight_q != '0))
    else $error("load channel %0d: response with no read in flight", ID);

endmodule

//--- hdl/store_channel.sv
`timescale 1ns/1ps
`include "streamer_macros.svh"

module store_channel (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      start_i,
  input  streamer_mem_pkg::addr_t   base_i,
  input  streamer_job_pkg::stride_t stride_i,
  input  streamer_job_pkg::count_t  len_i,
  input  logic                      z_valid_i,
  output logic                      z_ready_o,
  input  streamer_mem_pkg::data_t   z_data_i,
  output logic                      req_o,
  output streamer_mem_pkg::addr_t   addr_o,
  output streamer_mem_pkg::data_t   wdata_o,
  input  logic                      gnt_i,
  output logic                      idle_o
);

  streamer_job_pkg::count_t beats_left_q;
  logic                     ag_active;
  logic                     ag_last;
  logic                     full;
  logic                     empty;
  logic                     accept;
  logic                     issue;

  // Accept Z beats only up to the job length
  assign z_ready_o = (beats_left_q != '0) && !full;
  assign accept    = z_valid_i && z_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      beats_left_q <= '0;
    end else if (start_i) begin
      beats_left_q <= len_i;
    end else if (accept) begin
      beats_left_q <= beats_left_q - 1'b1;
    end
  end

  stream_fifo #(
    .DEPTH     (`STREAMER_STORE_DEPTH),
    .payload_t (streamer_mem_pkg::data_t)
  ) u_buf (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (accept),
    .data_i  (z_data_i),
    .full_o  (full),
    .pop_i   (issue),
    .data_o  (wdata_o),
    .empty_o (empty),
    .count_o ()
  );

  assign req_o = !empty;
  assign issue = req_o && gnt_i;

  addr_gen u_addr_gen (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .start_i  (start_i),
    .base_i   (base_i),
    .stride_i (stride_i),
    .len_i    (len_i),
    .next_i   (issue),
    .addr_o   (addr_o),
    .active_o (ag_active),
    .last_o   (ag_last)
  );

  // Unwritten addresses remain until the last write is granted
  assign idle_o = !ag_active && (beats_left_q == '0);

  last_write_after_last_beat: assert property (
    @(posedge clk_i) disable iff (rst_i) (issue && ag_last) |-> (beats_left_q == '0))
    else $error("store_channel: final write granted before the final Z beat");

endmodule

//--- hdl/mem_arbiter.sv
`timescale 1ns/1ps
`include "streamer_macros.svh"

module mem_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [3:0]              req_i,
  input  streamer_mem_pkg::addr_t addr_i [4],
  output logic [3:0]              gnt_o,
  input  streamer_mem_pkg::data_t wdata_i,
  output logic                    mem_req_o,
  output logic                    mem_we_o,
  output streamer_mem_pkg::addr_t mem_addr_o,
  output streamer_mem_pkg::data_t mem_wdata_o,
  input  logic                    mem_gnt_i,
  input  logic                    mem_rvalid_i,
  input  streamer_mem_pkg::data_t mem_rdata_i,
  output logic [2:0]              rvalid_o,
  output streamer_mem_pkg::data_t rdata_o
);

  streamer_job_pkg::stream_id_e sel;
  streamer_job_pkg::stream_id_e lock_id_q;
  streamer_mem_pkg::tag_t       tag_head;
  logic                         lock_q;
  logic                         sel_valid;
  logic                         tag_full;
  logic                         granted;

  // Fixed priority Z, Y, W, X and a waiting request keeps the port
  always_comb begin
    sel_valid = 1'b1;
    sel       = streamer_job_pkg::X;
    if (lock_q) begin
      sel = lock_id_q;
    end else if (req_i[streamer_job_pkg::Z]) begin
      sel = streamer_job_pkg::Z;
    end else if (!tag_full && req_i[streamer_job_pkg::Y]) begin
      sel = streamer_job_pkg::Y;
    end else if (!tag_full && req_i[streamer_job_pkg::W]) begin
      sel = streamer_job_pkg::W;
    end else if (!tag_full && req_i[streamer_job_pkg::X]) begin
      sel = streamer_job_pkg::X;
    end else begin
      sel_valid = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= mem_req_o && !mem_gnt_i;
    end
  end

  always_ff @(posedge clk_i) begin
    lock_id_q <= sel;
  end

  assign mem_req_o   = sel_valid;
  assign mem_we_o    = sel_valid && (sel == streamer_job_pkg::Z);
  assign mem_addr_o  = addr_i[sel];
  assign mem_wdata_o = wdata_i;
  assign granted     = mem_req_o && mem_gnt_i;
  assign gnt_o       = granted ? (4'b0001 << sel) : 4'b0000;

  // Owners of granted reads in grant order
  stream_fifo #(
    .DEPTH     (`STREAMER_TAG_DEPTH),
    .payload_t (streamer_mem_pkg::tag_t)
  ) u_tag_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (granted && !mem_we_o),
    .data_i  (streamer_mem_pkg::tag_t'(sel)),
    .full_o  (tag_full),
    .pop_i   (mem_rvalid_i),
    .data_o  (tag_head),
    .empty_o (),
    .count_o ()
  );

  for (genvar i = 0; i < 3; i++) begin : gen_route
    assign rvalid_o[i] = mem_rvalid_i && (tag_head == streamer_mem_pkg::tag_t'(i));
  end

  assign rdata_o = mem_rdata_i;

  one_grant_per_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(gnt_o) && ((gnt_o & ~req_i) == 4'b0000))
    else $error("mem_arbiter: grant to more than one stream or to a stream with no request");

endmodule

//--- hdl/streamer_top.sv
`timescale 1ns/1ps

module streamer_top (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      start_i,
  input  streamer_mem_pkg::addr_t   x_base_i,
  input  streamer_job_pkg::stride_t x_stride_i,
  input  streamer_job_pkg::count_t  x_len_i,
  input  streamer_mem_pkg::addr_t   w_base_i,
  input  streamer_job_pkg::stride_t w_stride_i,
  input  streamer_job_pkg::count_t  w_len_i,
  input  streamer_mem_pkg::addr_t   y_base_i,
  input  streamer_job_pkg::stride_t y_stride_i,
  input  streamer_job_pkg::count_t  y_len_i,
  input  streamer_mem_pkg::addr_t   z_base_i,
  input  streamer_job_pkg::stride_t z_stride_i,
  input  streamer_job_pkg::count_t  z_len_i,
  output logic                      x_valid_o,
  input  logic                      x_ready_i,
  output streamer_mem_pkg::data_t   x_data_o,
  output logic                      w_valid_o,
  input  logic                      w_ready_i,
  output streamer_mem_pkg::data_t   w_data_o,
  output logic                      y_valid_o,
  input  logic                      y_ready_i,
  output streamer_mem_pkg::data_t   y_data_o,
  input  logic                      z_valid_i,
  output logic                      z_ready_o,
  input  streamer_mem_pkg::data_t   z_data_i,
  output logic                      mem_req_o,
  output logic                      mem_we_o,
  output streamer_mem_pkg::addr_t   mem_addr_o,
  output streamer_mem_pkg::data_t   mem_wdata_o,
  input  logic                      mem_gnt_i,
  input  logic                      mem_rvalid_i,
  input  streamer_mem_pkg::data_t   mem_rdata_i,
  output logic                      busy_o,
  output logic                      done_o
);

  logic [3:0]              arb_req;
  logic [3:0]              arb_gnt;
  streamer_mem_pkg::addr_t arb_addr [4];
  streamer_mem_pkg::data_t z_wdata;
  logic [2:0]              arb_rvalid;
  streamer_mem_pkg::data_t arb_rdata;
  logic [3:0]              idle;
  logic                    start_job;
  logic                    busy_q;
  logic                    done_q;

  // A new job is taken only when the previous one has finished
  assign start_job = start_i && !busy_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= busy_q && (&idle);
      if (start_job) begin
        busy_q <= 1'b1;
      end else if (busy_q && (&idle)) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign busy_o = busy_q;
  assign done_o = done_q;

  load_channel #(
    .ID (streamer_job_pkg::X)
  ) u_load_x (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .start_i  (start_job),
    .base_i   (x_base_i),
    .stride_i (x_stride_i),
    .len_i    (x_len_i),
    .req_o    (arb_req[streamer_job_pkg::X]),
    .addr_o   (arb_addr[streamer_job_pkg::X]),
    .gnt_i    (arb_gnt[streamer_job_pkg::X]),
    .rvalid_i (arb_rvalid[streamer_job_pkg::X]),
    .rdata_i  (arb_rdata),
    .valid_o  (x_valid_o),
    .ready_i  (x_ready_i),
    .data_o   (x_data_o),
    .idle_o   (idle[streamer_job_pkg::X])
  );

  load_channel #(
    .ID (streamer_job_pkg::W)
  ) u_load_w (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .start_i  (start_job),
    .base_i   (w_base_i),
    .stride_i (w_stride_i),
    .len_i    (w_len_i),
    .req_o    (arb_req[streamer_job_pkg::W]),
    .addr_o   (arb_addr[streamer_job_pkg::W]),
    .gnt_i    (arb_gnt[streamer_job_pkg::W]),
    .rvalid_i (arb_rvalid[streamer_job_pkg::W]),
    .rdata_i  (arb_rdata),
    .valid_o  (w_valid_o),
    .ready_i  (w_ready_i),
    .data_o   (w_data_o),
    .idle_o   (idle[streamer_job_pkg::W])
  );

  load_channel #(
    .ID (streamer_job_pkg::Y)
  ) u_load_y (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .start_i  (start_job),
    .base_i   (y_base_i),
    .stride_i (y_stride_i),
    .len_i    (y_len_i),
    .req_o    (arb_req[streamer_job_pkg::Y]),
    .addr_o   (arb_addr[streamer_job_pkg::Y]),
    .gnt_i    (arb_gnt[streamer_job_pkg::Y]),
    .rvalid_i (arb_rvalid[streamer_job_pkg::Y]),
    .rdata_i  (arb_rdata),
    .valid_o  (y_valid_o),
    .ready_i  (y_ready_i),
    .data_o   (y_data_o),
    .idle_o   (idle[streamer_job_pkg::Y])
  );

  store_channel u_store_z (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .start_i   (start_job),
    .base_i    (z_base_i),
    .stride_i  (z_stride_i),
    .len_i     (z_len_i),
    .z_valid_i (z_valid_i),
    .z_ready_o (z_ready_o),
    .z_data_i  (z_data_i),
    .req_o     (arb_req[streamer_job_pkg::Z]),
    .addr_o    (arb_addr[streamer_job_pkg::Z]),
    .wdata_o   (z_wdata),
    .gnt_i     (arb_gnt[streamer_job_pkg::Z]),
    .idle_o    (idle[streamer_job_pkg::Z])
  );

  mem_arbiter u_arbiter (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (arb_req),
    .addr_i       (arb_addr),
    .gnt_o        (arb_gnt),
    .wdata_i      (z_wdata),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .rvalid_o     (arb_rvalid),
    .rdata_o      (arb_rdata)
  );

  // Memory traffic belongs to a running job only
  quiet_when_not_busy: assert property (
    @(posedge clk_i) disable iff (rst_i) !busy_q |-> !mem_req_o)
    else $error("streamer_top: memory request outside a job");

endmodule

//--- testbench/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [7:0]              gnt_pct_i,
  input  logic                    mem_req_i,
  input  logic                    mem_we_i,
  input  streamer_mem_pkg::addr_t mem_addr_i,
  input  streamer_mem_pkg::data_t mem_wdata_i,
  output logic                    mem_gnt_o,
  output logic                    mem_rvalid_o,
  output streamer_mem_pkg::data_t mem_rdata_o
);

  logic                    read_pend_q;
  streamer_mem_pkg::addr_t read_addr_q;
  int unsigned             wr_count = 0;
  int unsigned             req_cycles = 0;
  streamer_mem_pkg::addr_t wr_addr_log [256];
  streamer_mem_pkg::data_t wr_data_log [256];

  // Preloaded content that writes never change
  function automatic streamer_mem_pkg::data_t fill_word(streamer_mem_pkg::addr_t a);
    return {16'h0000, a} ^ 32'h5a5a_0000;
  endfunction

  initial begin
    mem_gnt_o    = 1'b0;
    mem_rvalid_o = 1'b0;
    mem_rdata_o  = '0;
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      read_pend_q <= 1'b0;
    end else begin
      read_pend_q <= mem_req_i && mem_gnt_o && !mem_we_i;
      read_addr_q <= mem_addr_i;
      if (mem_req_i) begin
        req_cycles <= req_cycles + 1;
      end
      if (mem_req_i && mem_gnt_o && mem_we_i) begin
        wr_addr_log[wr_count % 256] <= mem_addr_i;
        wr_data_log[wr_count % 256] <= mem_wdata_i;
        wr_count <= wr_count + 1;
      end
    end
  end

  // Grant and read response change on the falling edge
  always @(negedge clk_i) begin
    mem_gnt_o    <= ($urandom % 100) < gnt_pct_i;
    mem_rvalid_o <= read_pend_q;
    mem_rdata_o  <= read_pend_q ? fill_word(read_addr_q) : '0;
  end

endmodule

//--- testbench/tb_streamer.sv
`timescale 1ns/1ps

module tb_streamer;

  localparam int NJOBS   = 4;
  localparam int TIMEOUT = 3000;

  typedef struct packed {
    streamer_mem_pkg::addr_t   x_base;
    streamer_job_pkg::stride_t x_stride;
    streamer_job_pkg::count_t  x_len;
    streamer_mem_pkg::addr_t   w_base;
    streamer_job_pkg::stride_t w_stride;
    streamer_job_pkg::count_t  w_len;
    streamer_mem_pkg::addr_t   y_base;
    streamer_job_pkg::stride_t y_stride;
    streamer_job_pkg::count_t  y_len;
    streamer_mem_pkg::addr_t   z_base;
    streamer_job_pkg::stride_t z_stride;
    streamer_job_pkg::count_t  z_len;
    logic [7:0]                pct;
    logic [31:0]               seed;
  } job_row_t;

  // Each row holds base, stride and length of X, W, Y and Z,
  // the ready and grant percentage and the Z seed
  job_row_t jobs [NJOBS] = '{
    '{16'h0100, 8'd1, 8'd5, 16'h0200, 8'd1, 8'd4, 16'h0300, 8'd1, 8'd6,
      16'h8000, 8'd1, 8'd5, 8'd100, 32'h1234_0001},
    '{16'h0400, 8'd3, 8'd8, 16'h0500, 8'd2, 8'd3, 16'h0600, 8'd7, 8'd10,
      16'h8100, 8'd5, 8'd7, 8'd60, 32'hc0de_0002},
    // X wraps past the top of the address space
    '{16'hfff0, 8'h40, 8'd12, 16'h0a00, 8'hff, 8'd9, 16'h0b00, 8'd0, 8'd1,
      16'h9000, 8'd2, 8'd12, 8'd30, 32'hbeef_0003},
    '{16'h0c00, 8'd1, 8'd0, 16'h0d00, 8'd1, 8'd0, 16'h0e00, 8'd1, 8'd0,
      16'ha000, 8'd1, 8'd0, 8'd50, 32'h0000_0004}
  };

  logic clk_i = 1'b0;
  logic rst_i;
  logic start_i;
  streamer_mem_pkg::addr_t   x_base_i, w_base_i, y_base_i, z_base_i;
  streamer_job_pkg::stride_t x_stride_i, w_stride_i, y_stride_i, z_stride_i;
  streamer_job_pkg::count_t  x_len_i, w_len_i, y_len_i, z_len_i;
  logic x_valid_o, w_valid_o, y_valid_o, z_valid_i;
  logic x_ready_i, w_ready_i, y_ready_i, z_ready_o;
  streamer_mem_pkg::data_t   x_data_o, w_data_o, y_data_o, z_data_i;
  logic                      mem_req_o, mem_we_o, mem_gnt_i, mem_rvalid_i;
  streamer_mem_pkg::addr_t   mem_addr_o;
  streamer_mem_pkg::data_t   mem_wdata_o, mem_rdata_i;
  logic                      busy_o, done_o;

  logic [7:0]  cur_pct;
  logic [31:0] cur_seed;
  logic        job_go;
  logic        z_fire;
  int          z_idx;
  int          done_cnt = 0;
  int          errors = 0;
  int          tests = 0;
  int          failed_tests = 0;
  int          errs_before;
  bit          timed_out;
  streamer_mem_pkg::data_t x_got [$];
  streamer_mem_pkg::data_t w_got [$];
  streamer_mem_pkg::data_t y_got [$];

  streamer_top uut (.*);

  tb_mem_model u_mem (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .gnt_pct_i    (cur_pct),
    .mem_req_i    (mem_req_o),
    .mem_we_i     (mem_we_o),
    .mem_addr_i   (mem_addr_o),
    .mem_wdata_i  (mem_wdata_o),
    .mem_gnt_o    (mem_gnt_i),
    .mem_rvalid_o (mem_rvalid_i),
    .mem_rdata_o  (mem_rdata_i)
  );

  always #50 clk_i = ~clk_i;

  function automatic streamer_mem_pkg::addr_t word_addr(streamer_mem_pkg::addr_t base,
      streamer_job_pkg::stride_t stride, int k);
    return streamer_mem_pkg::addr_t'(base + k * stride);
  endfunction

  function automatic streamer_mem_pkg::data_t fill_word(streamer_mem_pkg::addr_t a);
    return {16'h0000, a} ^ 32'h5a5a_0000;
  endfunction

  // Z word k of a job
  function automatic streamer_mem_pkg::data_t z_word(logic [31:0] seed, int k);
    return seed ^ (k * 32'h9e37_79b9);
  endfunction

  task automatic check_data(string name, streamer_mem_pkg::data_t got,
      streamer_mem_pkg::data_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(string name, streamer_mem_pkg::addr_t got,
      streamer_mem_pkg::addr_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(string name, streamer_job_pkg::count_t got,
      streamer_job_pkg::count_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic score_stream(string name, streamer_mem_pkg::data_t got [$],
      streamer_mem_pkg::addr_t base, streamer_job_pkg::stride_t stride,
      streamer_job_pkg::count_t len);
    check_count({name, " beats"}, streamer_job_pkg::count_t'(got.size()), len);
    for (int k = 0; k < got.size() && k < len; k++) begin
      check_data($sformatf("%s[%0d]", name, k), got[k], fill_word(word_addr(base, stride, k)));
    end
  endtask

  task automatic score_writes(int first, job_row_t row);
    int n;
    n = u_mem.wr_count - first;
    check_count("write count", streamer_job_pkg::count_t'(n), row.z_len);
    for (int k = 0; k < n && k < row.z_len; k++) begin
      check_addr($sformatf("write addr[%0d]", k), u_mem.wr_addr_log[(first + k) % 256],
        word_addr(row.z_base, row.z_stride, k));
      check_data($sformatf("write data[%0d]", k), u_mem.wr_data_log[(first + k) % 256],
        z_word(row.seed, k));
    end
  endtask

  task automatic run_job(int idx, output bit late);
    job_row_t row;
    int done_before;
    int wr_before;
    int req_before;
    int cycles;
    row = jobs[idx];
    late = 1'b0;
    x_got.delete();
    w_got.delete();
    y_got.delete();
    done_before = done_cnt;
    wr_before   = u_mem.wr_count;
    req_before  = u_mem.req_cycles;
    cur_pct     = row.pct;
    cur_seed    = row.seed;
    {x_base_i, x_stride_i, x_len_i} = {row.x_base, row.x_stride, row.x_len};
    {w_base_i, w_stride_i, w_len_i} = {row.w_base, row.w_stride, row.w_len};
    {y_base_i, y_stride_i, y_len_i} = {row.y_base, row.y_stride, row.y_len};
    {z_base_i, z_stride_i, z_len_i} = {row.z_base, row.z_stride, row.z_len};
    // Producer starts over at Z word 0
    z_valid_i = 1'b0;
    z_idx     = 0;
    job_go  = 1'b1;
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    compare_flag("busy_o after start", busy_o, 1'b1);
    @(negedge clk_i);
    // A second start while busy must change nothing
    if (busy_o) begin
      start_i = 1'b1;
      @(negedge clk_i);
      start_i = 1'b0;
    end
    cycles = 0;
    while (done_cnt == done_before && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (done_cnt == done_before) begin
      $display("Timeout, done_o not seen within %0d cycles in row %0d", TIMEOUT, idx);
      late = 1'b1;
    end else begin
      compare_flag("busy_o after done", busy_o, 1'b0);
      check_count("x beats at done", streamer_job_pkg::count_t'(x_got.size()), row.x_len);
      check_count("w beats at done", streamer_job_pkg::count_t'(w_got.size()), row.w_len);
      check_count("y beats at done", streamer_job_pkg::count_t'(y_got.size()), row.y_len);
      check_count("writes at done",
        streamer_job_pkg::count_t'(u_mem.wr_count - wr_before), row.z_len);
      repeat (3) @(negedge clk_i);
      if (done_cnt != done_before + 1) begin
        $display("done_o pulsed %0d times in row %0d instead of once",
          done_cnt - done_before, idx);
        errors++;
      end
      if ({row.x_len, row.w_len, row.y_len, row.z_len} == '0 &&
          u_mem.req_cycles != req_before) begin
        $display("Memory request seen in row %0d, which has no words", idx);
        errors++;
      end
      score_stream("x_data", x_got, row.x_base, row.x_stride, row.x_len);
      score_stream("w_data", w_got, row.w_base, row.w_stride, row.w_len);
      score_stream("y_data", y_got, row.y_base, row.y_stride, row.y_len);
      score_writes(wr_before, row);
    end
    job_go = 1'b0;
  endtask

  // Beats and done pulses seen by the DUT at the rising edge
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (x_valid_o && x_ready_i) begin
        x_got.push_back(x_data_o);
      end
      if (w_valid_o && w_ready_i) begin
        w_got.push_back(w_data_o);
      end
      if (y_valid_o && y_ready_i) begin
        y_got.push_back(y_data_o);
      end
      if (done_o) begin
        done_cnt++;
      end
    end
    z_fire = z_valid_i && z_ready_o;
  end

  always @(negedge clk_i) begin
    x_ready_i = job_go && (($urandom % 100) < cur_pct);
    w_ready_i = job_go && (($urandom % 100) < cur_pct);
    y_ready_i = job_go && (($urandom % 100) < cur_pct);
  end

  // Z producer that holds a beat until it is taken
  always @(negedge clk_i) begin
    if (!job_go) begin
      z_valid_i = 1'b0;
      z_idx     = 0;
    end else if (!z_valid_i || z_fire) begin
      if (z_idx < z_len_i && ($urandom % 100) < cur_pct) begin
        z_valid_i = 1'b1;
        z_data_i  = z_word(cur_seed, z_idx);
        z_idx++;
      end else begin
        z_valid_i = 1'b0;
      end
    end
  end

  initial begin
    void'($urandom(32'ha747));
    rst_i     = 1'b1;
    start_i   = 1'b0;
    job_go    = 1'b0;
    cur_pct   = 8'd100;
    cur_seed  = '0;
    timed_out = 1'b0;
    {x_base_i, x_stride_i, x_len_i} = '0;
    {w_base_i, w_stride_i, w_len_i} = '0;
    {y_base_i, y_stride_i, y_len_i} = '0;
    {z_base_i, z_stride_i, z_len_i} = '0;
    {x_ready_i, w_ready_i, y_ready_i, z_valid_i, z_fire} = '0;
    z_data_i = '0;
    z_idx    = 0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    errs_before = errors;
    compare_flag("mem_req_o", mem_req_o, 1'b0);
    compare_flag("x_valid_o", x_valid_o, 1'b0);
    compare_flag("w_valid_o", w_valid_o, 1'b0);
    compare_flag("y_valid_o", y_valid_o, 1'b0);
    compare_flag("z_ready_o", z_ready_o, 1'b0);
    compare_flag("busy_o", busy_o, 1'b0);
    compare_flag("done_o", done_o, 1'b0);
    tests++;
    if (errors != errs_before) begin
      failed_tests++;
      $display("reset state: failed");
    end else begin
      $display("reset state: passed");
    end

    for (int i = 0; i < NJOBS && !timed_out; i++) begin
      errs_before = errors;
      run_job(i, timed_out);
      tests++;
      if (timed_out || errors != errs_before) begin
        failed_tests++;
        $display("row %0d: failed", i);
      end else begin
        $display("row %0d: passed", i);
      end
    end

    $display("%0d tests run, %0d failed, %0d check errors", tests, failed_tests, errors);
    if (!timed_out && failed_tests == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+hdl
hdl/streamer_mem_pkg.sv
hdl/streamer_job_pkg.sv
hdl/stream_fifo.sv
hdl/addr_gen.sv
hdl/load_channel.sv
hdl/store_channel.sv
hdl/mem_arbiter.sv
hdl/streamer_top.sv
testbench/tb_mem_model.sv
testbench/tb_streamer.sv
